//--- sim.f
+incdir+verif
src/deparser_pkg.sv
src/field_if.sv
src/action_cfg.sv
src/field_extract.sv
src/deparse_ctrl.sv
src/deparser.sv
verif/deparser_tb.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = deparser_tb
FLIST = sim.f
PASS  = All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS)"

clean:
	rm -rf obj_dir

//--- verif/deparser_tests.svh
// directed tests and the expected-beat model

function automatic int rand_below(input int n);
	int r;
	r = $random(seed);
	return (r & 32'h7fffffff) % n;
endfunction

function automatic logic [1151:0] rand_vec();
	logic [1151:0] v;
	for (int k = 0; k < 36; k++) begin
		v[32*k +: 32] = $random(seed);
	end
	return v;
endfunction

function automatic logic [15:0] make_action(input logic v, input int kind, input int idx,
	input int off);
	return {3'b000, off[6:0], kind[1:0], idx[2:0], v};
endfunction

// slot i sits at entry bit 244 - 16*i, low 100 bits unused
function automatic logic [ENTRY_W-1:0] pack_entry();
	logic [ENTRY_W-1:0] e;
	e = '0;
	for (int i = 0; i < N_ACTIONS; i++) begin
		e[244 - 16*i +: 16] = slot_acts[i];
	end
	return e;
endfunction

task automatic clear_slots();
	for (int i = 0; i < N_ACTIONS; i++) begin
		slot_acts[i] = '0;
	end
endtask

// random PHV whose vlan bits 7..4 select a table entry
function automatic logic [PHV_W-1:0] make_phv(input logic [3:0] addr);
	logic [1151:0] v;
	v = rand_vec();
	v[VLAN_POS+4 +: 4] = addr;
	return v[PHV_W-1:0];
endfunction

// slots in order, later ones win, bits past the header are lost
function automatic logic [2*DATA_W-1:0] apply_rewrite(input logic [2*DATA_W-1:0] hdr,
	input logic [PHV_W-1:0] phv, input logic [ENTRY_W-1:0] entry);
	logic [15:0] a;
	logic [47:0] val;
	int w;
	int pos;
	for (int i = 0; i < N_ACTIONS; i++) begin
		a = entry[244 - 16*i +: 16];
		w = 0;
		val = '0;
		if (a[0]) begin
			case (a[5:4])
				2'd1: begin
					w = 16;
					val = 48'(phv[PHV_2B_POS + 16*a[3:1] +: 16]);
				end
				2'd2: begin
					w = 32;
					val = 48'(phv[PHV_4B_POS + 32*a[3:1] +: 32]);
				end
				2'd3: begin
					w = 48;
					val = phv[PHV_6B_POS + 48*a[3:1] +: 48];
				end
				default: w = 0;
			endcase
		end
		for (int b = 0; b < w; b++) begin
			pos = 8*a[12:6] + b;
			if (pos < 2*DATA_W) begin
				hdr[pos] = val[b];
			end
		end
	end
	return hdr;
endfunction

// header beat, then one beat per entry in cfg_q
task automatic write_config(input logic [7:0] start, input logic [7:0] mod_id,
	input logic [15:0] flag, input int n);
	logic [DATA_W-1:0] beat;
	logic [1151:0] v;
	beat = '0;
	beat[391:384] = start;
	beat[375:368] = mod_id;
	beat[335:320] = flag;
	c_tdata <= beat;
	c_tvalid <= 1'b1;
	c_tlast <= (n == 0);
	@(posedge clk);
	for (int k = 0; k < n; k++) begin
		v = rand_vec();
		beat = v[DATA_W-1:0];
		beat[511:252] = cfg_q[k];
		c_tdata <= beat;
		c_tlast <= (k == n - 1);
		@(posedge clk);
	end
	c_tvalid <= 1'b0;
	c_tlast <= 1'b0;
	if (mod_id[2:0] == DEV_ID && flag == CTRL_FLAG) begin
		for (int k = 0; k < n; k++) begin
			tbl_model[4'(start[3:0] + k)] = cfg_q[k];
		end
	end
endtask

task automatic wait_input_accept();
	int cnt;
	cnt = 0;
	do begin
		@(posedge clk);
		cnt++;
	end while (!(pkt_in_tvalid && pkt_in_tready) && cnt < TIMEOUT);
	if (!(pkt_in_tvalid && pkt_in_tready)) abort_run("input beat was never accepted");
endtask

task automatic wait_output(input int n);
	int cnt;
	cnt = 0;
	while (out_data.size() < n && cnt < TIMEOUT) begin
		@(posedge clk);
		cnt++;
	end
	if (out_data.size() < n) abort_run("output packet never completed");
endtask

task automatic run_packet(input logic [PHV_W-1:0] phv, input int nbeats);
	logic [1151:0] v;
	logic [DATA_W-1:0] data [$];
	logic [KEEP_W-1:0] keep [$];
	logic [USER_W-1:0] user [$];
	logic [2*DATA_W-1:0] hdr;
	logic [DATA_W-1:0] exp;
	int base;
	int gap;
	for (int b = 0; b < nbeats; b++) begin
		v = rand_vec();
		data.push_back(v[DATA_W-1:0]);
		keep.push_back(v[DATA_W +: KEEP_W]);
		user.push_back(v[DATA_W+KEEP_W +: USER_W]);
	end
	hdr = '0;
	hdr[DATA_W-1:0] = data[0];
	if (nbeats > 1) begin
		hdr[2*DATA_W-1:DATA_W] = data[1];
	end
	hdr = apply_rewrite(hdr, phv, tbl_model[phv[VLAN_POS+4 +: 4]]);
	base = out_data.size();
	for (int b = 0; b < nbeats; b++) begin
		gap = gap_on ? rand_below(3) : 0;
		if (gap > 0) begin
			pkt_in_tvalid <= 1'b0;
			repeat (gap) @(posedge clk);
		end
		pkt_in_tdata <= data[b];
		pkt_in_tkeep <= keep[b];
		pkt_in_tuser <= user[b];
		pkt_in_tlast <= (b == nbeats - 1);
		pkt_in_tvalid <= 1'b1;
		if (b == 0) begin
			phv_data <= phv;
			phv_valid <= 1'b1;
		end
		wait_input_accept();
		if (b == 0) begin
			check("phv_ready", 512'(phv_ready), 512'(1'b1));
			phv_valid <= 1'b0;
		end
	end
	pkt_in_tvalid <= 1'b0;
	pkt_in_tlast <= 1'b0;
	wait_output(base + nbeats);
	repeat (2) @(posedge clk);
	check("pkt_out beats", 512'(out_data.size() - base), 512'(nbeats));
	for (int b = 0; b < nbeats && base + b < out_data.size(); b++) begin
		exp = (b == 0) ? hdr[DATA_W-1:0] : (b == 1) ? hdr[2*DATA_W-1:DATA_W] : data[b];
		check("pkt_out_tdata", 512'(out_data[base+b]), 512'(exp));
		check("pkt_out_tkeep", 512'(out_keep[base+b]), 512'(keep[b]));
		check("pkt_out_tuser", 512'(out_user[base+b]), 512'(user[b]));
		check("pkt_out_tlast", 512'(out_last[base+b]), 512'(b == nbeats - 1));
	end
endtask

task automatic test_basic();
	check("pkt_out_tvalid", 512'(pkt_out_tvalid), 512'(0));
	check("pkt_in_tready", 512'(pkt_in_tready), 512'(0));
	check("phv_ready", 512'(phv_ready), 512'(0));
	clear_slots();
	slot_acts[0] = make_action(1'b1, 1, 2, 3);
	slot_acts[1] = make_action(1'b1, 2, 5, 20);
	// straddles the beat boundary
	slot_acts[2] = make_action(1'b1, 3, 7, 62);
	// runs off the end of the header
	slot_acts[3] = make_action(1'b1, 3, 1, 126);
	cfg_q.delete();
	cfg_q.push_back(pack_entry());
	write_config(8'd2, 8'(DEV_ID), CTRL_FLAG, 1);
	run_packet(make_phv(4'd2), 3);
endtask

task automatic test_masking();
	clear_slots();
	slot_acts[0] = make_action(1'b0, 2, 1, 8);
	slot_acts[4] = make_action(1'b1, 1, 0, 10);
	slot_acts[5] = make_action(1'b1, 2, 3, 9);
	slot_acts[9] = make_action(1'b1, 1, 6, 11);
	cfg_q.delete();
	cfg_q.push_back(pack_entry());
	write_config(8'd7, 8'(DEV_ID), CTRL_FLAG, 1);
	run_packet(make_phv(4'd7), 2);
endtask

task automatic test_single_beat();
	run_packet(make_phv(4'd2), 1);
endtask

task automatic test_backpressure();
	bp_on <= 1'b1;
	gap_on = 1'b1;
	run_packet(make_phv(4'd2), 12);
	bp_on <= 1'b0;
	gap_on = 1'b0;
endtask

task automatic test_burst();
	cfg_q.delete();
	for (int e = 0; e < 4; e++) begin
		for (int i = 0; i < N_ACTIONS; i++) begin
			slot_acts[i] = make_action(1'b1, 1 + rand_below(3), rand_below(8),
				rand_below(128));
		end
		cfg_q.push_back(pack_entry());
	end
	write_config(8'd3, 8'(DEV_ID), CTRL_FLAG, 4);
	for (int e = 0; e < 4; e++) begin
		run_packet(make_phv(4'(3 + e)), 2);
	end
endtask

task automatic test_bad_ctrl();
	clear_slots();
	slot_acts[0] = make_action(1'b1, 3, 0, 0);
	cfg_q.delete();
	cfg_q.push_back(pack_entry());
	// wrong module id, then wrong flag
	write_config(8'd2, 8'h03, CTRL_FLAG, 1);
	write_config(8'd2, 8'(DEV_ID), 16'hf2f0, 1);
	run_packet(make_phv(4'd2), 2);
endtask

//--- verif/deparser_tb.sv
`timescale 1ns/100ps

module deparser_tb;
	import deparser_pkg::*;

	localparam logic [2:0] DEV_ID = 3'd5;
	localparam int TIMEOUT = 2000;

	logic                clk = 1'b0;
	logic                aresetn;
	logic [DATA_W-1:0]   pkt_in_tdata;
	logic [KEEP_W-1:0]   pkt_in_tkeep;
	logic [USER_W-1:0]   pkt_in_tuser;
	logic                pkt_in_tlast;
	logic                pkt_in_tvalid;
	logic                pkt_in_tready;
	logic [PHV_W-1:0]    phv_data;
	logic                phv_valid;
	logic                phv_ready;
	logic [DATA_W-1:0]   pkt_out_tdata;
	logic [KEEP_W-1:0]   pkt_out_tkeep;
	logic [USER_W-1:0]   pkt_out_tuser;
	logic                pkt_out_tlast;
	logic                pkt_out_tvalid;
	logic                pkt_out_tready = 1'b1;
	logic [DATA_W-1:0]   c_tdata;
	logic                c_tvalid;
	logic                c_tlast;

	int                  seed;
	int                  err_count;
	int                  n_checks;
	bit                  bp_on;
	bit                  gap_on;
	logic [63:0]         ready_pat;
	logic [5:0]          pat_pos = '0;
	logic [ENTRY_W-1:0]  tbl_model [TBL_DEPTH];
	logic [ENTRY_W-1:0]  cfg_q [$];
	logic [15:0]         slot_acts [N_ACTIONS];
	logic [DATA_W-1:0]   out_data [$];
	logic [KEEP_W-1:0]   out_keep [$];
	logic [USER_W-1:0]   out_user [$];
	logic                out_last [$];

	deparser #(
		.DEPARSER_ID(DEV_ID)
	) DUT (
		.clk            (clk),
		.aresetn        (aresetn),
		.pkt_in_tdata   (pkt_in_tdata),
		.pkt_in_tkeep   (pkt_in_tkeep),
		.pkt_in_tuser   (pkt_in_tuser),
		.pkt_in_tlast   (pkt_in_tlast),
		.pkt_in_tvalid  (pkt_in_tvalid),
		.pkt_in_tready  (pkt_in_tready),
		.phv_data       (phv_data),
		.phv_valid      (phv_valid),
		.phv_ready      (phv_ready),
		.pkt_out_tdata  (pkt_out_tdata),
		.pkt_out_tkeep  (pkt_out_tkeep),
		.pkt_out_tuser  (pkt_out_tuser),
		.pkt_out_tlast  (pkt_out_tlast),
		.pkt_out_tvalid (pkt_out_tvalid),
		.pkt_out_tready (pkt_out_tready),
		.c_tdata        (c_tdata),
		.c_tvalid       (c_tvalid),
		.c_tlast        (c_tlast)
	);

	always #50 clk = ~clk;

	// output stalls follow a random pattern
	always @(posedge clk) begin
		pat_pos <= pat_pos + 6'd1;
		pkt_out_tready <= !bp_on || ready_pat[pat_pos];
	end

	// collect every output beat
	always @(posedge clk) begin
		if (aresetn && pkt_out_tvalid && pkt_out_tready) begin
			out_data.push_back(pkt_out_tdata);
			out_keep.push_back(pkt_out_tkeep);
			out_user.push_back(pkt_out_tuser);
			out_last.push_back(pkt_out_tlast);
		end
	end

	task automatic check(input string name, input logic [511:0] got, input logic [511:0] exp);
		n_checks++;
		if (got !== exp) begin
			err_count++;
			$display("ERROR: %s got %0h expected %0h", name, got, exp);
		end
	endtask

	task automatic abort_run(input string what);
		$display("timeout while waiting: %s", what);
		$display("checks: %0d, errors: %0d", n_checks, err_count);
		$display("Test failures found");
		$finish;
	endtask

	`include "deparser_tests.svh"

	initial begin
		seed = 18;
		err_count = 0;
		n_checks = 0;
		bp_on = 1'b0;
		gap_on = 1'b0;
		ready_pat = {32'($random(seed)), 32'($random(seed))};
		aresetn = 1'b0;
		pkt_in_tdata = '0;
		pkt_in_tkeep = '0;
		pkt_in_tuser = '0;
		pkt_in_tlast = 1'b0;
		pkt_in_tvalid = 1'b0;
		phv_data = '0;
		phv_valid = 1'b0;
		c_tdata = '0;
		c_tvalid = 1'b0;
		c_tlast = 1'b0;
		repeat (2) @(posedge clk);
		aresetn <= 1'b1;
		@(posedge clk);
		test_basic();
		test_masking();
		test_single_beat();
		test_backpressure();
		test_burst();
		test_bad_ctrl();
		$display("checks: %0d, errors: %0d", n_checks, err_count);
		if (err_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- src/deparser.sv
`timescale 1ns/100ps

module deparser #(
	parameter logic [2:0] DEPARSER_ID = 3'd5
) (
	input  logic                               clk,
	input  logic                               aresetn,

	input  logic [deparser_pkg::DATA_W-1:0]    pkt_in_tdata,
	input  logic [deparser_pkg::KEEP_W-1:0]    pkt_in_tkeep,
	input  logic [deparser_pkg::USER_W-1:0]    pkt_in_tuser,
	input  logic                               pkt_in_tlast,
	input  logic                               pkt_in_tvalid,
	output logic                               pkt_in_tready,

	input  logic [deparser_pkg::PHV_W-1:0]     phv_data,
	input  logic                               phv_valid,
	output logic                               phv_ready,

	output logic [deparser_pkg::DATA_W-1:0]    pkt_out_tdata,
	output logic [deparser_pkg::KEEP_W-1:0]    pkt_out_tkeep,
	output logic [deparser_pkg::USER_W-1:0]    pkt_out_tuser,
	output logic                               pkt_out_tlast,
	output logic                               pkt_out_tvalid,
	input  logic                               pkt_out_tready,

	input  logic [deparser_pkg::DATA_W-1:0]    c_tdata,
	input  logic                               c_tvalid,
	input  logic                               c_tlast
);
	import deparser_pkg::*;

	logic [3:0]         rd_addr;
	logic [ENTRY_W-1:0] rd_entry;
	logic [PHV_W-1:0]   phv_hold;

	field_if fld_bus ();

	action_cfg #(
		.DEPARSER_ID(DEPARSER_ID)
	) u_cfg (
		.clk      (clk),
		.aresetn  (aresetn),
		.c_tdata  (c_tdata),
		.c_tvalid (c_tvalid),
		.c_tlast  (c_tlast),
		.rd_addr  (rd_addr),
		.rd_entry (rd_entry)
	);

	deparse_ctrl u_ctrl (
		.clk            (clk),
		.aresetn        (aresetn),
		.pkt_in_tdata   (pkt_in_tdata),
		.pkt_in_tkeep   (pkt_in_tkeep),
		.pkt_in_tuser   (pkt_in_tuser),
		.pkt_in_tlast   (pkt_in_tlast),
		.pkt_in_tvalid  (pkt_in_tvalid),
		.pkt_in_tready  (pkt_in_tready),
		.phv_data       (phv_data),
		.phv_valid      (phv_valid),
		.phv_ready      (phv_ready),
		.pkt_out_tdata  (pkt_out_tdata),
		.pkt_out_tkeep  (pkt_out_tkeep),
		.pkt_out_tuser  (pkt_out_tuser),
		.pkt_out_tlast  (pkt_out_tlast),
		.pkt_out_tvalid (pkt_out_tvalid),
		.pkt_out_tready (pkt_out_tready),
		.rd_addr        (rd_addr),
		.rd_entry       (rd_entry),
		.phv_hold       (phv_hold),
		.fld            (fld_bus.ctrl)
	);

	// one extractor per action slot
	for (genvar i = 0; i < N_ACTIONS; i++) begin : g_slot
		field_extract #(
			.SLOT(i)
		) u_fx (
			.clk      (clk),
			.aresetn  (aresetn),
			.phv_data (phv_hold),
			.fld      (fld_bus.slot)
		);
	end

endmodule

//--- src/deparse_ctrl.sv
`timescale 1ns/100ps

module deparse_ctrl (
	input  logic                               clk,
	input  logic                               aresetn,

	input  logic [deparser_pkg::DATA_W-1:0]    pkt_in_tdata,
	input  logic [deparser_pkg::KEEP_W-1:0]    pkt_in_tkeep,
	input  logic [deparser_pkg::USER_W-1:0]    pkt_in_tuser,
	input  logic                               pkt_in_tlast,
	input  logic                               pkt_in_tvalid,
	output logic                               pkt_in_tready,

	input  logic [deparser_pkg::PHV_W-1:0]     phv_data,
	input  logic                               phv_valid,
	output logic                               phv_ready,

	output logic [deparser_pkg::DATA_W-1:0]    pkt_out_tdata,
	output logic [deparser_pkg::KEEP_W-1:0]    pkt_out_tkeep,
	output logic [deparser_pkg::USER_W-1:0]    pkt_out_tuser,
	output logic                               pkt_out_tlast,
	output logic                               pkt_out_tvalid,
	input  logic                               pkt_out_tready,

	output logic [3:0]                         rd_addr,
	input  logic [deparser_pkg::ENTRY_W-1:0]   rd_entry,
	output logic [deparser_pkg::PHV_W-1:0]     phv_hold,
	field_if.ctrl                              fld
);
	import deparser_pkg::*;

	dp_state_t             state;
	logic                  start;
	logic                  in_fire;
	logic                  out_fire;
	logic [2*DATA_W-1:0]   hdr_q;
	logic [KEEP_W-1:0]     keep_q [2];
	logic [USER_W-1:0]     user_q [2];
	logic [1:0]            last_q;
	action_t               act_q [N_ACTIONS];
	// header plus room for a field hanging off the end
	logic [2*DATA_W+47:0]  work;

	assign start = (state == IDLE) && phv_valid && pkt_in_tvalid;
	assign phv_ready = start;
	assign pkt_in_tready = start || (state == HDR_1) || ((state == PASS) && pkt_out_tready);
	assign in_fire = pkt_in_tvalid && pkt_in_tready;
	assign out_fire = pkt_out_tvalid && pkt_out_tready;

	// table address from vlan id bits 7..4
	assign rd_addr = phv_hold[VLAN_POS+4 +: 4];
	assign fld.actions = act_q;
	assign fld.load = (state == EXTRACT);

	// later slots overwrite earlier ones
	always_comb begin
		work = {48'd0, hdr_q};
		for (int i = 0; i < N_ACTIONS; i++) begin
			case (fld.kinds[i])
				KIND_2B: work[{act_q[i].offset, 3'b000} +: 16] = fld.values[i][15:0];
				KIND_4B: work[{act_q[i].offset, 3'b000} +: 32] = fld.values[i][31:0];
				KIND_6B: work[{act_q[i].offset, 3'b000} +: 48] = fld.values[i];
				default: ;
			endcase
		end
	end

	always_comb begin
		pkt_out_tvalid = 1'b0;
		pkt_out_tdata = pkt_in_tdata;
		pkt_out_tkeep = pkt_in_tkeep;
		pkt_out_tuser = pkt_in_tuser;
		pkt_out_tlast = pkt_in_tlast;
		case (state)
			OUT_0: begin
				pkt_out_tvalid = 1'b1;
				pkt_out_tdata = hdr_q[DATA_W-1:0];
				pkt_out_tkeep = keep_q[0];
				pkt_out_tuser = user_q[0];
				pkt_out_tlast = last_q[0];
			end
			OUT_1: begin
				pkt_out_tvalid = 1'b1;
				pkt_out_tdata = hdr_q[2*DATA_W-1:DATA_W];
				pkt_out_tkeep = keep_q[1];
				pkt_out_tuser = user_q[1];
				pkt_out_tlast = last_q[1];
			end
			PASS: pkt_out_tvalid = pkt_in_tvalid;
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: if (start) state <= pkt_in_tlast ? READ : HDR_1;
				HDR_1: if (in_fire) state <= READ;
				READ: state <= LOAD;
				LOAD: state <= EXTRACT;
				EXTRACT: state <= REWRITE;
				REWRITE: state <= OUT_0;
				OUT_0: if (out_fire) state <= last_q[0] ? IDLE : OUT_1;
				OUT_1: if (out_fire) state <= last_q[1] ? IDLE : PASS;
				PASS: if (out_fire && pkt_in_tlast) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			phv_hold <= phv_data;
			hdr_q[DATA_W-1:0] <= pkt_in_tdata;
			keep_q[0] <= pkt_in_tkeep;
			user_q[0] <= pkt_in_tuser;
			last_q[0] <= pkt_in_tlast;
		end
		if ((state == HDR_1) && in_fire) begin
			hdr_q[2*DATA_W-1:DATA_W] <= pkt_in_tdata;
			keep_q[1] <= pkt_in_tkeep;
			user_q[1] <= pkt_in_tuser;
			last_q[1] <= pkt_in_tlast;
		end
		// slot 0 sits at the top of the entry
		if (state == LOAD) begin
			for (int i = 0; i < N_ACTIONS; i++) begin
				act_q[i] <= rd_entry[ENTRY_W-16*(i+1) +: 16];
			end
		end
		if (state == REWRITE) begin
			hdr_q <= work[2*DATA_W-1:0];
		end
	end

	a_out_stable: assert property (
		@(posedge clk) disable iff (!aresetn)
		pkt_out_tvalid && !pkt_out_tready |=> pkt_out_tvalid && $stable(pkt_out_tdata)
	) else $error("pkt_out_tdata changed while stalled");

endmodule

//--- src/field_extract.sv
`timescale 1ns/100ps

module field_extract #(
	parameter int SLOT = 0
) (
	input  logic                             clk,
	input  logic                             aresetn,
	input  logic [deparser_pkg::PHV_W-1:0]   phv_data,
	field_if.slot                            fld
);
	import deparser_pkg::*;

	action_t     act;
	logic [47:0] sel_val;
	logic [47:0] val_q;
	logic [1:0]  kind_q;

	assign act = fld.actions[SLOT];

	// pick the container, zero extended
	always_comb begin
		case (act.kind)
			KIND_2B: sel_val = {32'd0, phv_data[PHV_2B_POS + 16*act.index +: 16]};
			KIND_4B: sel_val = {16'd0, phv_data[PHV_4B_POS + 32*act.index +: 32]};
			KIND_6B: sel_val = phv_data[PHV_6B_POS + 48*act.index +: 48];
			default: sel_val = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (fld.load) begin
			val_q <= sel_val;
		end
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			kind_q <= KIND_NONE;
		end else if (fld.load) begin
			kind_q <= act.valid ? act.kind : KIND_NONE;
		end
	end

	assign fld.values[SLOT] = val_q;
	assign fld.kinds[SLOT] = kind_q;

	a_valid_has_kind: assert property (
		@(posedge clk) disable iff (!aresetn)
		fld.load && act.valid |=> kind_q != KIND_NONE
	) else $error("slot %0d: valid action with kind 0", SLOT);

endmodule

//--- src/action_cfg.sv
`timescale 1ns/100ps

module action_cfg #(
	parameter logic [2:0] DEPARSER_ID = 3'd5
) (
	input  logic                               clk,
	input  logic                               aresetn,
	input  logic [deparser_pkg::DATA_W-1:0]    c_tdata,
	input  logic                               c_tvalid,
	input  logic                               c_tlast,
	input  logic [3:0]                         rd_addr,
	output logic [deparser_pkg::ENTRY_W-1:0]   rd_entry
);
	import deparser_pkg::*;

	ctrl_word_u         c_word;
	logic               hdr_match;
	logic               writing;
	logic               wr_en;
	logic [3:0]         wr_idx;
	logic [ENTRY_W-1:0] table_mem [TBL_DEPTH];

	assign c_word = c_tdata;

	// only the low three bits of the module id are significant
	assign hdr_match = c_tvalid && (c_word.hdr.mod_id[2:0] == DEPARSER_ID) &&
		(c_word.hdr.flag == CTRL_FLAG);

	assign wr_en = writing && c_tvalid;

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			writing <= 1'b0;
			wr_idx <= '0;
		end else if (!writing) begin
			// a header with tlast carries no entries
			if (hdr_match && !c_tlast) begin
				writing <= 1'b1;
				wr_idx <= c_word.hdr.start_idx[3:0];
			end
		end else if (c_tvalid) begin
			wr_idx <= wr_idx + 4'd1;
			if (c_tlast) begin
				writing <= 1'b0;
			end
		end
	end

	// table storage, registered read
	always_ff @(posedge clk) begin
		if (wr_en) begin
			table_mem[wr_idx] <= c_word.ent.entry;
		end
		rd_entry <= table_mem[rd_addr];
	end

	// start index must name an existing entry
	a_start_in_table: assert property (
		@(posedge clk) disable iff (!aresetn)
		!writing && hdr_match && !c_tlast |-> c_word.hdr.start_idx < TBL_DEPTH
	) else $error("control burst start index beyond the table");

endmodule

//--- src/field_if.sv
`timescale 1ns/100ps

interface field_if;
	import deparser_pkg::*;

	action_t     actions [N_ACTIONS];
	logic        load;
	// one result per action slot
	logic [47:0] values [N_ACTIONS];
	logic [1:0]  kinds [N_ACTIONS];

	modport ctrl (
		output actions,
		output load,
		input  values,
		input  kinds
	);

	modport slot (
		input  actions,
		input  load,
		output values,
		output kinds
	);

endinterface

//--- src/deparser_pkg.sv
package deparser_pkg;

	localparam int DATA_W = 512;
	localparam int KEEP_W = DATA_W / 8;
	localparam int USER_W = 128;
	localparam int PHV_W = 1124;

	// container bank bases inside the PHV
	localparam int PHV_2B_POS = 356;
	localparam int PHV_4B_POS = 484;
	localparam int PHV_6B_POS = 740;
	localparam int VLAN_POS = 129;

	localparam int N_ACTIONS = 10;
	localparam int TBL_DEPTH = 16;
	localparam int ENTRY_W = 260;
	localparam logic [15:0] CTRL_FLAG = 16'hf2f1;

	localparam logic [1:0] KIND_NONE = 2'd0;
	localparam logic [1:0] KIND_2B = 2'd1;
	localparam logic [1:0] KIND_4B = 2'd2;
	localparam logic [1:0] KIND_6B = 2'd3;

	typedef struct packed {
		logic [2:0] spare;
		logic [6:0] offset;
		logic [1:0] kind;
		logic [2:0] index;
		logic       valid;
	} action_t;

	// first beat of a control burst
	typedef struct packed {
		logic [119:0] rsvd_hi;
		logic [7:0]   start_idx;
		logic [7:0]   rsvd_mid;
		logic [7:0]   mod_id;
		logic [31:0]  rsvd_lo;
		logic [15:0]  flag;
		logic [319:0] rsvd_tail;
	} ctrl_hdr_t;

	typedef struct packed {
		logic [ENTRY_W-1:0]        entry;
		logic [DATA_W-ENTRY_W-1:0] rsvd;
	} ctrl_entry_t;

	typedef union packed {
		ctrl_hdr_t   hdr;
		ctrl_entry_t ent;
	} ctrl_word_u;

	typedef enum logic [3:0] {
		IDLE, HDR_1, READ, LOAD, EXTRACT, REWRITE, OUT_0, OUT_1, PASS
	} dp_state_t;

endpackage
